// ==== hdl/gfx_settings.svh ====
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// 640x480 at 60 Hz, horizontal timing in pixels
`define GFX_H_ACTIVE      640
`define GFX_H_SYNC_START  656
`define GFX_H_SYNC_END    752
`define GFX_H_TOTAL       800

// vertical timing in lines
`define GFX_V_ACTIVE      480
`define GFX_V_SYNC_START  490
`define GFX_V_SYNC_END    492
`define GFX_V_TOTAL       525

// solid square sprites
`define GFX_NUM_SPRITES   4
`define GFX_SPRITE_SIZE   16

`define GFX_ADDR_BITS     12
`define GFX_DATA_BITS     16

// host address map
`define GFX_REG_FRAME     12'hF00
`define GFX_REG_LINE      12'hF01
`define GFX_REG_COLLIDE   12'h700
`define GFX_REG_BGCOLOR   12'hD20
`define GFX_PAGE_PALETTE  4'hE
`define GFX_PAGE_SPRITE   4'h0

`endif

// ==== hdl/gfx_pkg.sv ====
`include "gfx_settings.svh"

package gfx_pkg;

	typedef logic [9:0] coord_t;

	// red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] rgb12_t;

	typedef logic [7:0] pal_index_t;

	typedef logic [`GFX_ADDR_BITS-1:0] gfx_addr_t;
	typedef logic [`GFX_DATA_BITS-1:0] gfx_data_t;

	typedef struct packed {
		coord_t     x;
		coord_t     y;
		pal_index_t index;
		logic       enable;
	} sprite_t;

	typedef sprite_t [`GFX_NUM_SPRITES-1:0] sprite_table_t;

	// scan position as seen by the pixel pipeline
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   hs;
		logic   vs;
	} beam_t;

endpackage

// ==== hdl/video_timing.sv ====
`include "gfx_settings.svh"

module video_timing import gfx_pkg::*;
(
	input  logic  CLK,
	input  logic  arst_n,
	output beam_t beam,
	output logic  frame_start
);

	coord_t x;
	coord_t y;

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			x <= '0;
			y <= '0;
		end
		else if (x == coord_t'(`GFX_H_TOTAL - 1))
		begin
			x <= '0;
			// new line, wrap at the end of the frame
			if (y == coord_t'(`GFX_V_TOTAL - 1))
				y <= '0;
			else
				y <= y + 1'b1;
		end
		else
		begin
			x <= x + 1'b1;
		end
	end

	always_comb
	begin
		beam.x      = x;
		beam.y      = y;
		beam.active = (x < coord_t'(`GFX_H_ACTIVE)) && (y < coord_t'(`GFX_V_ACTIVE));
		// both syncs are active low
		beam.hs     = !((x >= coord_t'(`GFX_H_SYNC_START)) && (x < coord_t'(`GFX_H_SYNC_END)));
		beam.vs     = !((y >= coord_t'(`GFX_V_SYNC_START)) && (y < coord_t'(`GFX_V_SYNC_END)));
	end

	assign frame_start = (x == '0) && (y == '0);

endmodule

// ==== hdl/gfx_regs.sv ====
`include "gfx_settings.svh"

module gfx_regs import gfx_pkg::*;
(
	input  logic                        CLK,
	input  logic                        arst_n,
	input  gfx_addr_t                   addr,
	input  gfx_data_t                   wdata,
	input  logic                        wr,
	input  logic                        frame_start,
	input  coord_t                      line,
	input  logic [`GFX_NUM_SPRITES-1:0] collide_hits,
	output gfx_data_t                   rdata,
	output sprite_table_t               sprites,
	output rgb12_t                      bg_color,
	output logic                        pal_wr,
	output pal_index_t                  pal_addr,
	output rgb12_t                      pal_data
);

	logic [5:0]                  frame_count;
	logic [`GFX_NUM_SPRITES-1:0] collide;
	gfx_addr_t                   addr_q;
	logic                        sprite_page;

	assign sprite_page = (addr[11:8] == `GFX_PAGE_SPRITE);

	// sprite fields at sprite*4 + field, plus the background colour
	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sprites  <= '0;
			bg_color <= '0;
		end
		else if (wr)
		begin
			for (int i = 0; i < `GFX_NUM_SPRITES; i++)
			begin
				if (sprite_page && (addr[7:2] == 6'(i)))
				begin
					case (addr[1:0])
						2'd0: sprites[i].x      <= wdata[9:0];
						2'd1: sprites[i].y      <= wdata[9:0];
						2'd2: sprites[i].index  <= wdata[7:0];
						2'd3: sprites[i].enable <= wdata[0];
					endcase
				end
			end
			if (addr == `GFX_REG_BGCOLOR)
				bg_color <= wdata[11:0];
		end
	end

	// palette writes go straight through to the RAM
	assign pal_wr   = wr && (addr[11:8] == `GFX_PAGE_PALETTE);
	assign pal_addr = addr[7:0];
	assign pal_data = wdata[11:0];

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_count <= '0;
			collide     <= '0;
			addr_q      <= '0;
		end
		else
		begin
			addr_q <= addr;
			if (frame_start)
				frame_count <= frame_count + 1'b1;
			// sticky until the host writes the register
			if (wr && (addr == `GFX_REG_COLLIDE))
				collide <= '0;
			else
				collide <= collide | collide_hits;
		end
	end

	always_comb
	begin
		rdata = '0;
		case (addr_q)
			`GFX_REG_FRAME:   rdata[5:0] = frame_count;
			`GFX_REG_LINE:    rdata[9:0] = line;
			`GFX_REG_COLLIDE: rdata[`GFX_NUM_SPRITES-1:0] = collide;
			default:          rdata = '0;
		endcase
	end

endmodule

// ==== hdl/palette_ram.sv ====
module palette_ram import gfx_pkg::*;
(
	input  logic       CLK,
	input  pal_index_t rd_index,
	input  logic       wr,
	input  pal_index_t wr_index,
	input  rgb12_t     wr_color,
	output rgb12_t     rd_color
);

	rgb12_t mem [0:255];

	// host write port
	always_ff @(posedge CLK)
	begin
		if (wr)
			mem[wr_index] <= wr_color;
	end

	// pixel read, one cycle of latency
	always_ff @(posedge CLK)
	begin
		rd_color <= mem[rd_index];
	end

endmodule

// ==== hdl/sprite_engine.sv ====
`include "gfx_settings.svh"

module sprite_engine import gfx_pkg::*;
(
	input  logic                        CLK,
	input  logic                        arst_n,
	input  beam_t                       beam,
	input  sprite_table_t               sprites,
	output pal_index_t                  hit_index,
	output logic                        hit,
	output logic [`GFX_NUM_SPRITES-1:0] collide_hits,
	output beam_t                       beam_d
);

	logic [`GFX_NUM_SPRITES-1:0] covers;
	pal_index_t                  win_index;

	// hit test per sprite with 11-bit sums so the far edge cannot wrap
	for (genvar i = 0; i < `GFX_NUM_SPRITES; i++)
	begin : g_hit
		logic [10:0] x_end;
		logic [10:0] y_end;

		assign x_end = {1'b0, sprites[i].x} + 11'(`GFX_SPRITE_SIZE - 1);
		assign y_end = {1'b0, sprites[i].y} + 11'(`GFX_SPRITE_SIZE - 1);

		assign covers[i] = sprites[i].enable &&
			(beam.x >= sprites[i].x) && ({1'b0, beam.x} <= x_end) &&
			(beam.y >= sprites[i].y) && ({1'b0, beam.y} <= y_end);
	end

	// walk down so the lowest-numbered sprite is applied last and wins
	always_comb
	begin
		win_index = '0;
		for (int i = `GFX_NUM_SPRITES - 1; i >= 0; i--)
		begin
			if (covers[i])
				win_index = sprites[i].index;
		end
	end

	// palette address comes from the winner of this cycle
	assign hit_index = win_index;

	// overlap of two or more sprites on a visible pixel
	assign collide_hits = (beam.active && ($countones(covers) >= 2)) ? covers : '0;

	// stage 1 registers where index 0 counts as no hit
	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hit           <= 1'b0;
			beam_d.x      <= '0;
			beam_d.y      <= '0;
			beam_d.active <= 1'b0;
			beam_d.hs     <= 1'b1;
			beam_d.vs     <= 1'b1;
		end
		else
		begin
			hit    <= (win_index != '0);
			beam_d <= beam;
		end
	end

endmodule

// ==== hdl/pixel_mixer.sv ====
module pixel_mixer import gfx_pkg::*;
(
	input  logic       CLK,
	input  logic       arst_n,
	input  beam_t      beam_d,
	input  logic       hit,
	input  rgb12_t     pal_color,
	input  rgb12_t     bg_color,
	output logic       hs,
	output logic       vs,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	rgb12_t pix;

	// no sprite or a sprite with index 0 shows the background
	always_comb
	begin
		if (!beam_d.active)
			pix = '0;
		else if (hit)
			pix = pal_color;
		else
			pix = bg_color;
	end

	// colour and syncs leave on the same edge
	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hs    <= 1'b1;
			vs    <= 1'b1;
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
		else
		begin
			hs    <= beam_d.hs;
			vs    <= beam_d.vs;
			red   <= pix[11:8];
			green <= pix[7:4];
			blue  <= pix[3:0];
		end
	end

endmodule

// ==== hdl/gfx_top.sv ====
`include "gfx_settings.svh"

module gfx_top import gfx_pkg::*;
(
	input  logic       CLK,
	input  logic       arst_n,
	input  gfx_addr_t  addr,
	input  gfx_data_t  wdata,
	input  logic       wr,
	output gfx_data_t  rdata,
	output logic       hs,
	output logic       vs,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	beam_t                       beam;
	beam_t                       beam_d;
	logic                        frame_start;
	sprite_table_t               sprites;
	rgb12_t                      bg_color;
	logic                        pal_wr;
	pal_index_t                  pal_addr;
	rgb12_t                      pal_data;
	rgb12_t                      pal_color;
	pal_index_t                  hit_index;
	logic                        hit;
	logic [`GFX_NUM_SPRITES-1:0] collide_hits;

	video_timing u_video_timing (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.beam        (beam),
		.frame_start (frame_start)
	);

	gfx_regs u_gfx_regs (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.addr         (addr),
		.wdata        (wdata),
		.wr           (wr),
		.frame_start  (frame_start),
		.line         (beam.y),
		.collide_hits (collide_hits),
		.rdata        (rdata),
		.sprites      (sprites),
		.bg_color     (bg_color),
		.pal_wr       (pal_wr),
		.pal_addr     (pal_addr),
		.pal_data     (pal_data)
	);

	palette_ram u_palette_ram (
		.CLK      (CLK),
		.rd_index (hit_index),
		.wr       (pal_wr),
		.wr_index (pal_addr),
		.wr_color (pal_data),
		.rd_color (pal_color)
	);

	sprite_engine u_sprite_engine (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.beam         (beam),
		.sprites      (sprites),
		.hit_index    (hit_index),
		.hit          (hit),
		.collide_hits (collide_hits),
		.beam_d       (beam_d)
	);

	pixel_mixer u_pixel_mixer (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.beam_d    (beam_d),
		.hit       (hit),
		.pal_color (pal_color),
		.bg_color  (bg_color),
		.hs        (hs),
		.vs        (vs),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

// ==== tests/tb_gfx.sv ====
`include "gfx_settings.svh"

module tb_gfx import gfx_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES   = `GFX_H_TOTAL * `GFX_V_TOTAL;
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;

	typedef enum logic [2:0] {ST_WRITE, ST_READ, ST_LINE, ST_FRAME, ST_PIXEL} step_kind_t;

	// one row of the stimulus table
	typedef struct packed {
		step_kind_t kind;
		gfx_addr_t  addr;
		gfx_data_t  data;
		coord_t     x;
		coord_t     y;
	} step_t;

	logic       CLK;
	logic       arst_n;
	gfx_addr_t  addr;
	gfx_data_t  wdata;
	logic       wr;
	gfx_data_t  rdata;
	logic       hs;
	logic       vs;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;

	step_t steps [$];

	// reference model, beam follows the DUT from reset release
	int     m_x     = 0;
	int     m_y     = 0;
	int     m_frame = 0;
	int     m_sx [`GFX_NUM_SPRITES];
	int     m_sy [`GFX_NUM_SPRITES];
	int     m_sidx [`GFX_NUM_SPRITES];
	bit     m_sen [`GFX_NUM_SPRITES];
	rgb12_t m_pal [256];
	rgb12_t m_bg = '0;

	int cycles   = 0;
	int hs_cnt   = 0;
	int vs_lines = 0;

	gfx_top u_gfx_top (
		.CLK    (CLK),
		.arst_n (arst_n),
		.addr   (addr),
		.wdata  (wdata),
		.wr     (wr),
		.rdata  (rdata),
		.hs     (hs),
		.vs     (vs),
		.red    (red),
		.green  (green),
		.blue   (blue)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	always @(posedge CLK)
	begin
		if (arst_n)
		begin
			if (m_x == `GFX_H_TOTAL - 1)
			begin
				m_x <= 0;
				m_y <= (m_y == `GFX_V_TOTAL - 1) ? 0 : m_y + 1;
			end
			else
			begin
				m_x <= m_x + 1;
			end
			// frame starts at the top left pixel
			if ((m_x == 0) && (m_y == 0))
				m_frame <= m_frame + 1;
		end
	end

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles without reaching the end of the tests", cycles);
			$display("TB FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// sync widths and horizontal blanking, outputs lag the beam by two
	always @(negedge CLK)
	begin
		if (arst_n)
		begin
			if (!hs)
				hs_cnt = hs_cnt + 1;
			if (m_x == 400 && !vs)
				vs_lines = vs_lines + 1;
			if ((m_x >= `GFX_H_ACTIVE + 2) || (m_x < 2))
			begin
				assert ({red, green, blue} == 12'h000)
				else report_failure($sformatf("colour %h in horizontal blanking", {red, green, blue}));
			end
			if (m_x == `GFX_H_TOTAL - 1)
			begin
				assert (hs_cnt == `GFX_H_SYNC_END - `GFX_H_SYNC_START)
				else report_failure($sformatf("hs low for %0d cycles in line %0d", hs_cnt, m_y));
				hs_cnt = 0;
				if (m_y == `GFX_V_TOTAL - 1)
				begin
					assert (vs_lines == `GFX_V_SYNC_END - `GFX_V_SYNC_START)
					else report_failure($sformatf("vs low for %0d lines", vs_lines));
					vs_lines = 0;
				end
			end
		end
	end

	function automatic void model_write(input gfx_addr_t a, input gfx_data_t d);
		int s;
		s = int'(a[7:2]);
		if ((a[11:8] == `GFX_PAGE_SPRITE) && (s < `GFX_NUM_SPRITES))
		begin
			case (a[1:0])
				2'd0: m_sx[s] = int'(d[9:0]);
				2'd1: m_sy[s] = int'(d[9:0]);
				2'd2: m_sidx[s] = int'(d[7:0]);
				default: m_sen[s] = d[0];
			endcase
		end
		else if (a[11:8] == `GFX_PAGE_PALETTE)
			m_pal[a[7:0]] = d[11:0];
		else if (a == `GFX_REG_BGCOLOR)
			m_bg = d[11:0];
	endfunction

	function automatic rgb12_t expected_pixel(input int px, input int py);
		int win;
		win = -1;
		for (int i = 0; i < `GFX_NUM_SPRITES; i++)
		begin
			if ((win < 0) && m_sen[i] && (px >= m_sx[i]) && (px < m_sx[i] + `GFX_SPRITE_SIZE)
				&& (py >= m_sy[i]) && (py < m_sy[i] + `GFX_SPRITE_SIZE))
				win = i;
		end
		if ((win < 0) || (m_sidx[win] == 0))
			return m_bg;
		return m_pal[m_sidx[win]];
	endfunction

	task automatic bus_write(input gfx_addr_t a, input gfx_data_t d);
		@(posedge CLK);
		addr  <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge CLK);
		wr    <= 1'b0;
		model_write(a, d);
	endtask

	task automatic bus_read(input gfx_addr_t a, output gfx_data_t v);
		@(posedge CLK);
		addr <= a;
		@(posedge CLK);
		@(negedge CLK);
		v = rdata;
	endtask

	task automatic probe_pixel(input int px, input int py);
		rgb12_t want;
		rgb12_t got;
		want = expected_pixel(px, py);
		@(negedge CLK);
		while (!((m_x == px) && (m_y == py)))
		begin
			@(negedge CLK);
		end
		// colour leaves the pipeline two cycles later
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		got = {red, green, blue};
		assert (got == want)
		else report_failure($sformatf("pixel (%0d,%0d) is %h, expected %h", px, py, got, want));
	endtask

	task automatic check_frame_count(input gfx_addr_t a);
		gfx_data_t first;
		gfx_data_t second;
		bus_read(a, first);
		assert (first == gfx_data_t'(m_frame % 64))
		else report_failure($sformatf("frame count %0d, expected %0d", first, m_frame % 64));
		// two samples exactly one frame apart
		repeat (FRAME_CYCLES - 2) @(posedge CLK);
		bus_read(a, second);
		assert (second[5:0] == first[5:0] + 6'd1)
		else report_failure($sformatf("frame count went from %0d to %0d", first, second));
	endtask

	task automatic run_step(input step_t s);
		gfx_data_t v;
		case (s.kind)
			ST_WRITE: bus_write(s.addr, s.data);
			ST_READ:
			begin
				bus_read(s.addr, v);
				assert (v == s.data)
				else report_failure($sformatf("read %h gave %h, expected %h", s.addr, v, s.data));
			end
			ST_LINE:
			begin
				bus_read(s.addr, v);
				assert (v == gfx_data_t'(m_y))
				else report_failure($sformatf("line read %0d, beam at line %0d", v, m_y));
			end
			ST_FRAME: check_frame_count(s.addr);
			default: probe_pixel(int'(s.x), int'(s.y));
		endcase
	endtask

	function automatic void add_step(input step_kind_t kind, input gfx_addr_t a,
		input gfx_data_t d, input int x, input int y);
		step_t s;
		s.kind = kind;
		s.addr = a;
		s.data = d;
		s.x    = coord_t'(x);
		s.y    = coord_t'(y);
		steps.push_back(s);
	endfunction

	function automatic void place_sprite(input int n, input int x, input int y,
		input pal_index_t idx);
		add_step(ST_WRITE, gfx_addr_t'(n * 4), gfx_data_t'(x), 0, 0);
		add_step(ST_WRITE, gfx_addr_t'(n * 4 + 1), gfx_data_t'(y), 0, 0);
		add_step(ST_WRITE, gfx_addr_t'(n * 4 + 2), gfx_data_t'(idx), 0, 0);
		add_step(ST_WRITE, gfx_addr_t'(n * 4 + 3), 16'd1, 0, 0);
	endfunction

	// probes are listed in raster order so each one lands in the current frame
	function automatic void build_steps();
		int         x1, y1, x3, y3, x0, y0;
		pal_index_t i1, i0, i2;
		rgb12_t     bg, c1, c0, c2;
		bg = rgb12_t'($urandom_range(1, 4095));
		c1 = bg ^ rgb12_t'($urandom_range(1, 4095));
		c0 = bg ^ rgb12_t'($urandom_range(1, 4095));
		c2 = c0 ^ rgb12_t'($urandom_range(1, 4095));
		i1 = pal_index_t'($urandom_range(1, 99));
		i0 = pal_index_t'($urandom_range(100, 179));
		i2 = pal_index_t'($urandom_range(180, 255));
		x1 = int'($urandom_range(20, 600));
		y1 = int'($urandom_range(100, 200));
		x3 = int'($urandom_range(20, 600));
		y3 = int'($urandom_range(260, 300));
		x0 = int'($urandom_range(20, 580));
		y0 = int'($urandom_range(360, 420));
		// background only
		add_step(ST_WRITE, `GFX_REG_BGCOLOR, gfx_data_t'(bg), 0, 0);
		add_step(ST_PIXEL, '0, '0, 10, 20);
		add_step(ST_PIXEL, '0, '0, 639, 100);
		add_step(ST_PIXEL, '0, '0, 320, 479);
		// sprite 1 through the palette, sprite 3 with index 0
		add_step(ST_WRITE, {`GFX_PAGE_PALETTE, 8'h00}, gfx_data_t'(~bg), 0, 0);
		add_step(ST_WRITE, {`GFX_PAGE_PALETTE, i1}, gfx_data_t'(c1), 0, 0);
		place_sprite(1, x1, y1, i1);
		place_sprite(3, x3, y3, 8'h00);
		add_step(ST_PIXEL, '0, '0, x1, y1);
		add_step(ST_PIXEL, '0, '0, x1 + 16, y1 + 2);
		add_step(ST_PIXEL, '0, '0, x1 - 1, y1 + 5);
		add_step(ST_PIXEL, '0, '0, x1 + 7, y1 + 8);
		add_step(ST_PIXEL, '0, '0, x1 + 15, y1 + 15);
		add_step(ST_PIXEL, '0, '0, x1, y1 + 16);
		add_step(ST_PIXEL, '0, '0, x3 + 4, y3 + 4);
		// overlapping sprites 0 and 2
		add_step(ST_WRITE, {`GFX_PAGE_PALETTE, i0}, gfx_data_t'(c0), 0, 0);
		add_step(ST_WRITE, {`GFX_PAGE_PALETTE, i2}, gfx_data_t'(c2), 0, 0);
		add_step(ST_WRITE, `GFX_REG_COLLIDE, 16'h0000, 0, 0);
		place_sprite(0, x0, y0, i0);
		place_sprite(2, x0 + 8, y0 + 8, i2);
		add_step(ST_PIXEL, '0, '0, x0 + 10, y0 + 10);
		add_step(ST_PIXEL, '0, '0, x0 + 20, y0 + 20);
		add_step(ST_READ, `GFX_REG_COLLIDE, 16'h0005, 0, 0);
		add_step(ST_WRITE, 12'h003, 16'h0000, 0, 0);
		add_step(ST_WRITE, 12'h00B, 16'h0000, 0, 0);
		add_step(ST_WRITE, `GFX_REG_COLLIDE, 16'h0000, 0, 0);
		add_step(ST_READ, `GFX_REG_COLLIDE, 16'h0000, 0, 0);
		// status registers
		add_step(ST_LINE, `GFX_REG_LINE, '0, 0, 0);
		add_step(ST_FRAME, `GFX_REG_FRAME, '0, 0, 0);
	endfunction

	initial
	begin
		void'($urandom(48));
		arst_n = 1'b0;
		addr   = '0;
		wdata  = '0;
		wr     = 1'b0;
		repeat (2) @(posedge CLK);
		arst_n <= 1'b1;
		build_steps();
		foreach (steps[i])
		begin
			run_step(steps[i]);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/gfx_pkg.sv
hdl/video_timing.sv
hdl/gfx_regs.sv
hdl/palette_ram.sv
hdl/sprite_engine.sv
hdl/pixel_mixer.sv
hdl/gfx_top.sv
tests/tb_gfx.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_gfx
FLIST       ?= tb.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing -j 0
EXTRA_FLAGS ?=

SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the simulator exits non-zero when the testbench stops on an error
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
